// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := wb_stage_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST))
PASS_MSG  := Finished with no errors

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/wb_stage_tb.sv
`timescale 1ns/1ps

module wb_stage_tb;

    localparam int unsigned SEED         = 32'h9c71;
    localparam int          RESET_CYCLES = 10;
    localparam int          ITEM_CYCLES  = 3;
    localparam int          BB_ITEMS     = 7;
    // reset, 59 single items and the back-to-back run with its drain
    localparam int TEST_CYCLES    = RESET_CYCLES + ITEM_CYCLES * 59 + BB_ITEMS + 3;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                    clk;
    logic                    rst_n;
    logic                    ex_valid;
    wb_types_pkg::reg_addr_t ex_rd;
    wb_types_pkg::wr_sel_e   ex_wr_sel;
    wb_types_pkg::load_e     ex_load;
    wb_types_pkg::word_t     ex_alu_result;
    wb_types_pkg::word_t     ex_pc_plus4;
    wb_types_pkg::word_t     dmem_rdata;
    wb_types_pkg::word_t     bios_rdata;
    logic [1:0]              uart_status;
    logic [7:0]              uart_rx;
    wb_types_pkg::word_t     conv_result;
    logic                    wb_we;
    wb_types_pkg::reg_addr_t wb_addr;
    wb_types_pkg::word_t     wb_data;
    wb_types_pkg::word_t     wb_fwd_data;
    logic                    wb_is_load;

    // MMIO values that run_item presents in the read cycle
    logic [1:0]              next_status;
    logic [7:0]              next_rx;
    wb_types_pkg::word_t     next_conv;

    int          cycle_count;
    int          errors;
    int          errors_mark;
    int          tests_done;
    int unsigned seed_draw;

    wb_stage_top wb_stage_top_inst (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .ex_valid_i      (ex_valid),
        .ex_rd_i         (ex_rd),
        .ex_wr_sel_i     (ex_wr_sel),
        .ex_load_i       (ex_load),
        .ex_alu_result_i (ex_alu_result),
        .ex_pc_plus4_i   (ex_pc_plus4),
        .dmem_rdata_i    (dmem_rdata),
        .bios_rdata_i    (bios_rdata),
        .uart_status_i   (uart_status),
        .uart_rx_i       (uart_rx),
        .conv_result_i   (conv_result),
        .wb_we_o         (wb_we),
        .wb_addr_o       (wb_addr),
        .wb_data_o       (wb_data),
        .wb_fwd_data_o   (wb_fwd_data),
        .wb_is_load_o    (wb_is_load)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests were still running after %0d cycles", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // **********************************************************************
    // compare tasks and reference rules
    // **********************************************************************

    task automatic check_word(input string name, input wb_types_pkg::word_t got,
                              input wb_types_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input wb_types_pkg::reg_addr_t got,
                              input wb_types_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %0t ns %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %0t ns %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        if (errors == errors_mark)
            $display("test %s: passed", name);
        else
            $display("test %s: %0d errors", name, errors - errors_mark);
        errors_mark = errors;
    endtask

    // a byte comes from any offset, a halfword from the half the offset falls in
    function automatic wb_types_pkg::word_t expected_load(input wb_types_pkg::load_e ld,
            input wb_types_pkg::byte_off_t off, input wb_types_pkg::word_t w);
        wb_types_pkg::word_t b_word;
        wb_types_pkg::word_t h_word;
        b_word = w >> (8 * off);
        h_word = w >> (16 * off[1]);
        case (ld)
            wb_types_pkg::LD_B:  return {{24{b_word[7]}}, b_word[7:0]};
            wb_types_pkg::LD_H:  return {{16{h_word[15]}}, h_word[15:0]};
            wb_types_pkg::LD_BU: return {24'h0, b_word[7:0]};
            wb_types_pkg::LD_HU: return {16'h0, h_word[15:0]};
            default:             return w;
        endcase
    endfunction

    function automatic wb_types_pkg::load_e load_kind(input int idx);
        case (idx)
            0:       return wb_types_pkg::LD_B;
            1:       return wb_types_pkg::LD_H;
            2:       return wb_types_pkg::LD_W;
            3:       return wb_types_pkg::LD_BU;
            default: return wb_types_pkg::LD_HU;
        endcase
    endfunction

    function automatic wb_types_pkg::reg_addr_t random_rd();
        return wb_types_pkg::reg_addr_t'($urandom_range(31, 1));
    endfunction

    function automatic wb_types_pkg::word_t mmio_addr(input wb_map_pkg::mmio_off_t off);
        return {wb_map_pkg::MMIO_NIBBLE, 20'h0, off};
    endfunction

    // **********************************************************************
    // single item: EX fields, then read data, then the registered write
    // **********************************************************************

    task automatic run_item(input wb_types_pkg::reg_addr_t rd, input wb_types_pkg::wr_sel_e wsel,
                            input wb_types_pkg::load_e ld, input wb_types_pkg::word_t addr,
                            input wb_types_pkg::word_t pc4, input wb_types_pkg::word_t dmem,
                            input wb_types_pkg::word_t bios, input wb_types_pkg::word_t value);
        @(posedge clk);
        #2;
        ex_valid      = 1'b1;
        ex_rd         = rd;
        ex_wr_sel     = wsel;
        ex_load       = ld;
        ex_alu_result = addr;
        ex_pc_plus4   = pc4;
        @(posedge clk);
        #2;
        check_word("wb_fwd_data_o", wb_fwd_data, (wsel == wb_types_pkg::WR_PC4) ? pc4 : addr);
        check_bit("wb_is_load_o", wb_is_load, wsel == wb_types_pkg::WR_LOAD);
        ex_valid    = 1'b0;
        dmem_rdata  = dmem;
        bios_rdata  = bios;
        uart_status = next_status;
        uart_rx     = next_rx;
        conv_result = next_conv;
        @(posedge clk);
        #2;
        check_bit("wb_we_o", wb_we, rd != '0);
        check_addr("wb_addr_o", wb_addr, rd);
        check_word("wb_data_o", wb_data, (rd == '0) ? '0 : value);
        // the stage register now holds a bubble, so no load is in flight
        check_bit("wb_is_load_o", wb_is_load, 1'b0);
    endtask

    // **********************************************************************
    // tests
    // **********************************************************************

    task automatic test_reset();
        check_bit("wb_we_o", wb_we, 1'b0);
        check_bit("wb_is_load_o", wb_is_load, 1'b0);
        check_word("wb_data_o", wb_data, '0);
        check_word("wb_fwd_data_o", wb_fwd_data, '0);
        finish_test("reset state");
    endtask

    task automatic test_alu_pc4();
        wb_types_pkg::word_t alu;
        wb_types_pkg::word_t pc4;
        for (int i = 0; i < 8; i++) begin
            alu = $urandom;
            pc4 = $urandom;
            if (i % 2 == 0)
                run_item(random_rd(), wb_types_pkg::WR_ALU, wb_types_pkg::LD_W, alu, pc4,
                         '0, '0, alu);
            else
                run_item(random_rd(), wb_types_pkg::WR_PC4, wb_types_pkg::LD_W, alu, pc4,
                         '0, '0, pc4);
        end
        finish_test("alu and pc+4 writeback");
    endtask

    // the other memory gets the inverted word so a wrong region shows up
    task automatic sweep_loads(input string name, input logic [3:0] nibble, input bit use_bios);
        wb_types_pkg::word_t     mem_word;
        wb_types_pkg::word_t     addr;
        wb_types_pkg::load_e     ld;
        wb_types_pkg::byte_off_t off;
        for (int k = 0; k < 5; k++) begin
            for (int o = 0; o < 4; o++) begin
                ld       = load_kind(k);
                off      = wb_types_pkg::byte_off_t'(o);
                mem_word = $urandom;
                addr     = {nibble, 26'($urandom), off};
                if (use_bios)
                    run_item(random_rd(), wb_types_pkg::WR_LOAD, ld, addr, $urandom,
                             ~mem_word, mem_word, expected_load(ld, off, mem_word));
                else
                    run_item(random_rd(), wb_types_pkg::WR_LOAD, ld, addr, $urandom,
                             mem_word, ~mem_word, expected_load(ld, off, mem_word));
            end
        end
        finish_test(name);
    endtask

    task automatic test_mmio();
        wb_types_pkg::word_t junk;
        junk        = $urandom;
        next_status = 2'($urandom_range(3, 1));
        next_rx     = 8'h80 | 8'($urandom);
        next_conv   = $urandom;
        for (int i = 0; i < 2; i++) begin
            run_item(random_rd(), wb_types_pkg::WR_LOAD, load_kind(i * 3),
                     mmio_addr(wb_map_pkg::UART_STATUS_OFF), '0, junk, junk, {30'h0, next_status});
            run_item(random_rd(), wb_types_pkg::WR_LOAD, load_kind(i * 3),
                     mmio_addr(wb_map_pkg::UART_RX_OFF), '0, junk, junk, {24'h0, next_rx});
            run_item(random_rd(), wb_types_pkg::WR_LOAD, load_kind(i + 1),
                     mmio_addr(wb_map_pkg::CONV_RESULT_OFF), '0, junk, junk, next_conv);
        end
        run_item(random_rd(), wb_types_pkg::WR_LOAD, wb_types_pkg::LD_W, mmio_addr(8'h08),
                 '0, junk, junk, '0);
        run_item(random_rd(), wb_types_pkg::WR_LOAD, wb_types_pkg::LD_W,
                 {4'h2, 28'($urandom)}, '0, junk, junk, '0);
        finish_test("mmio loads");
    endtask

    task automatic test_x0();
        wb_types_pkg::word_t word;
        word = $urandom;
        run_item('0, wb_types_pkg::WR_ALU, wb_types_pkg::LD_W, word, ~word, '0, '0, word);
        run_item('0, wb_types_pkg::WR_PC4, wb_types_pkg::LD_W, word, ~word, '0, '0, ~word);
        run_item('0, wb_types_pkg::WR_LOAD, wb_types_pkg::LD_W, {4'h1, 28'h0}, '0,
                 word, word, word);
        finish_test("x0 suppression");
    endtask

    // one item per cycle with a bubble at index 4, read data one cycle after each item
    task automatic test_back_to_back();
        logic                    bb_valid [BB_ITEMS];
        wb_types_pkg::reg_addr_t bb_rd    [BB_ITEMS];
        wb_types_pkg::wr_sel_e   bb_sel   [BB_ITEMS];
        wb_types_pkg::word_t     bb_alu   [BB_ITEMS];
        wb_types_pkg::word_t     bb_pc4   [BB_ITEMS];
        wb_types_pkg::word_t     bb_mem   [BB_ITEMS];
        int                      j;
        for (int i = 0; i < BB_ITEMS; i++) begin
            bb_valid[i] = (i != 4);
            bb_rd[i]    = random_rd();
            bb_sel[i]   = (i % 3 == 0) ? wb_types_pkg::WR_ALU :
                          (i % 3 == 1) ? wb_types_pkg::WR_PC4 : wb_types_pkg::WR_LOAD;
            bb_alu[i]   = (i % 3 == 2) ? {4'h1, 26'($urandom), 2'b00} : $urandom;
            bb_pc4[i]   = $urandom;
            bb_mem[i]   = $urandom;
        end
        for (int s = 0; s < BB_ITEMS + 2; s++) begin
            @(posedge clk);
            #2;
            if (s >= 2) begin
                j = s - 2;
                check_bit("wb_we_o", wb_we, bb_valid[j]);
                if (bb_valid[j]) begin
                    check_addr("wb_addr_o", wb_addr, bb_rd[j]);
                    check_word("wb_data_o", wb_data,
                               (bb_sel[j] == wb_types_pkg::WR_ALU) ? bb_alu[j] :
                               (bb_sel[j] == wb_types_pkg::WR_PC4) ? bb_pc4[j] : bb_mem[j]);
                end
            end
            if (s >= 1)
                dmem_rdata = bb_mem[s - 1];
            ex_valid = 1'b0;
            if (s < BB_ITEMS) begin
                ex_valid      = bb_valid[s];
                ex_rd         = bb_rd[s];
                ex_wr_sel     = bb_sel[s];
                ex_load       = wb_types_pkg::LD_W;
                ex_alu_result = bb_alu[s];
                ex_pc_plus4   = bb_pc4[s];
            end
        end
        finish_test("back-to-back items");
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        ex_valid      = 1'b0;
        ex_rd         = '0;
        ex_wr_sel     = wb_types_pkg::WR_ALU;
        ex_load       = wb_types_pkg::LD_W;
        ex_alu_result = '0;
        ex_pc_plus4   = '0;
        dmem_rdata    = '0;
        bios_rdata    = '0;
        uart_status   = '0;
        uart_rx       = '0;
        conv_result   = '0;
        next_status   = '0;
        next_rx       = '0;
        next_conv     = '0;
        cycle_count   = 0;
        errors        = 0;
        errors_mark   = 0;
        tests_done    = 0;
        seed_draw     = $urandom(SEED);
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_alu_pc4();
        sweep_loads("data memory loads", wb_map_pkg::DMEM_NIBBLE, 1'b0);
        sweep_loads("bios loads", wb_map_pkg::BIOS_NIBBLE, 1'b1);
        test_mmio();
        test_x0();
        test_back_to_back();
        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: flist.f
logic/wb_types_pkg.sv
logic/wb_map_pkg.sv
logic/wb_sel_if.sv
logic/wb_ctrl.sv
logic/load_align.sv
logic/mmio_read_mux.sv
logic/wb_result_mux.sv
logic/wb_stage_top.sv
dv/wb_stage_tb.sv

// File: logic/load_align.sv
`timescale 1ns/1ps

module load_align (
    wb_sel_if.align              sel,
    input  wb_types_pkg::word_t  rdata_i,
    output wb_types_pkg::word_t  load_o
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // **********************************************************************
    // extraction
    // **********************************************************************

    always_comb begin
        case (sel.byte_off)
            2'd0:    byte_val = rdata_i[7:0];
            2'd1:    byte_val = rdata_i[15:8];
            2'd2:    byte_val = rdata_i[23:16];
            default: byte_val = rdata_i[31:24];
        endcase
    end

    // a misaligned halfword falls back to the aligned half it sits in
    assign half_val = sel.byte_off[1] ? rdata_i[31:16] : rdata_i[15:0];

    // **********************************************************************
    // extension
    // **********************************************************************

    always_comb begin
        case (sel.load)
            wb_types_pkg::LD_B: begin
                load_o = {{24{byte_val[7]}}, byte_val};
            end
            wb_types_pkg::LD_H: begin
                load_o = {{16{half_val[15]}}, half_val};
            end
            wb_types_pkg::LD_BU: begin
                load_o = {24'h0, byte_val};
            end
            wb_types_pkg::LD_HU: begin
                load_o = {16'h0, half_val};
            end
            default: begin
                // word loads ignore the low address bits
                load_o = rdata_i;
            end
        endcase
    end

endmodule

// File: logic/mmio_read_mux.sv
`timescale 1ns/1ps

module mmio_read_mux (
    wb_sel_if.mmio               sel,
    input  wb_types_pkg::word_t  dmem_load_i,
    input  wb_types_pkg::word_t  bios_load_i,
    input  logic [1:0]           uart_status_i,
    input  logic [7:0]           uart_rx_i,
    input  wb_types_pkg::word_t  conv_result_i,
    output wb_types_pkg::word_t  load_data_o
);

    wb_types_pkg::word_t mmio_word;

    // **********************************************************************
    // memory-mapped registers
    // **********************************************************************

    // the load type plays no part here, registers always come back whole
    always_comb begin
        case (sel.mmio_off)
            wb_map_pkg::UART_STATUS_OFF: begin
                mmio_word = {30'h0, uart_status_i};
            end
            wb_map_pkg::UART_RX_OFF: begin
                mmio_word = {24'h0, uart_rx_i};
            end
            wb_map_pkg::CONV_RESULT_OFF: begin
                mmio_word = conv_result_i;
            end
            default: begin
                mmio_word = '0;
            end
        endcase
    end

    // **********************************************************************
    // region select
    // **********************************************************************

    always_comb begin
        case (sel.region)
            wb_map_pkg::RG_DMEM: load_data_o = dmem_load_i;
            wb_map_pkg::RG_BIOS: load_data_o = bios_load_i;
            wb_map_pkg::RG_MMIO: load_data_o = mmio_word;
            default:             load_data_o = '0;
        endcase
    end

endmodule

// File: logic/wb_ctrl.sv
`timescale 1ns/1ps

module wb_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ex_valid_i,
    input  wb_types_pkg::reg_addr_t ex_rd_i,
    input  wb_types_pkg::wr_sel_e   ex_wr_sel_i,
    input  wb_types_pkg::load_e     ex_load_i,
    input  wb_types_pkg::word_t     ex_alu_result_i,
    input  wb_types_pkg::word_t     ex_pc_plus4_i,
    wb_sel_if.ctrl                  sel
);

    logic                    valid_q;
    wb_types_pkg::reg_addr_t rd_q;
    wb_types_pkg::wr_sel_e   wr_sel_q;
    wb_types_pkg::load_e     load_q;
    wb_types_pkg::word_t     alu_result_q;
    wb_types_pkg::word_t     pc_plus4_q;
    logic [3:0]              addr_nibble;

    // **********************************************************************
    // EX/WB stage register
    // **********************************************************************

    // fields hold their last value while no new item arrives
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q      <= 1'b0;
            rd_q         <= '0;
            wr_sel_q     <= wb_types_pkg::WR_ALU;
            load_q       <= wb_types_pkg::LD_W;
            alu_result_q <= '0;
            pc_plus4_q   <= '0;
        end else begin
            valid_q <= ex_valid_i;
            if (ex_valid_i) begin
                rd_q         <= ex_rd_i;
                wr_sel_q     <= ex_wr_sel_i;
                load_q       <= ex_load_i;
                alu_result_q <= ex_alu_result_i;
                pc_plus4_q   <= ex_pc_plus4_i;
            end
        end
    end

    // **********************************************************************
    // load address decode
    // **********************************************************************

    assign addr_nibble = alu_result_q[wb_map_pkg::NIBBLE_MSB:wb_map_pkg::NIBBLE_LSB];

    always_comb begin
        case (addr_nibble)
            wb_map_pkg::DMEM_NIBBLE: sel.region = wb_map_pkg::RG_DMEM;
            wb_map_pkg::BIOS_NIBBLE: sel.region = wb_map_pkg::RG_BIOS;
            wb_map_pkg::MMIO_NIBBLE: sel.region = wb_map_pkg::RG_MMIO;
            default:                 sel.region = wb_map_pkg::RG_NONE;
        endcase
    end

    assign sel.byte_off   = alu_result_q[1:0];
    assign sel.mmio_off   = alu_result_q[wb_map_pkg::MMIO_OFF_W-1:0];

    assign sel.valid      = valid_q;
    assign sel.rd         = rd_q;
    assign sel.wr_sel     = wr_sel_q;
    assign sel.load       = load_q;
    assign sel.alu_result = alu_result_q;
    assign sel.pc_plus4   = pc_plus4_q;

endmodule

// File: logic/wb_map_pkg.sv
package wb_map_pkg;

    // **********************************************************************
    // address regions
    // **********************************************************************

    typedef enum logic [1:0] {
        RG_DMEM = 2'b00,
        RG_BIOS = 2'b01,
        RG_MMIO = 2'b10,
        RG_NONE = 2'b11
    } region_e;

    // the region is chosen by the top nibble of the load address
    localparam int unsigned NIBBLE_MSB = 31;
    localparam int unsigned NIBBLE_LSB = 28;

    localparam logic [3:0] DMEM_NIBBLE = 4'h1;
    localparam logic [3:0] BIOS_NIBBLE = 4'h4;
    localparam logic [3:0] MMIO_NIBBLE = 4'h8;

    // **********************************************************************
    // memory-mapped register offsets
    // **********************************************************************

    localparam int unsigned MMIO_OFF_W = 8;

    typedef logic [MMIO_OFF_W-1:0] mmio_off_t;

    localparam mmio_off_t UART_STATUS_OFF = 8'h00;
    localparam mmio_off_t UART_RX_OFF     = 8'h04;
    localparam mmio_off_t CONV_RESULT_OFF = 8'h10;

endpackage

// File: logic/wb_result_mux.sv
`timescale 1ns/1ps

module wb_result_mux (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    wb_sel_if.result                 sel,
    input  wb_types_pkg::word_t      load_data_i,
    output logic                     wb_we_o,
    output wb_types_pkg::reg_addr_t  wb_addr_o,
    output wb_types_pkg::word_t      wb_data_o,
    output wb_types_pkg::word_t      wb_fwd_data_o,
    output logic                     wb_is_load_o
);

    wb_types_pkg::word_t fwd_data;
    wb_types_pkg::word_t final_data;
    logic                rd_is_x0;

    // **********************************************************************
    // result select
    // **********************************************************************

    // the forwarding value never depends on load data
    assign fwd_data = (sel.wr_sel == wb_types_pkg::WR_PC4) ? sel.pc_plus4 : sel.alu_result;

    assign final_data = (sel.wr_sel == wb_types_pkg::WR_LOAD) ? load_data_i : fwd_data;

    assign rd_is_x0 = (sel.rd == '0);

    // the hazard unit stalls on this flag since load data is not ready in EX
    assign wb_is_load_o  = sel.valid && (sel.wr_sel == wb_types_pkg::WR_LOAD);
    assign wb_fwd_data_o = fwd_data;

    // **********************************************************************
    // register file write
    // **********************************************************************

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_we_o   <= 1'b0;
            wb_addr_o <= '0;
            wb_data_o <= '0;
        end else begin
            wb_we_o   <= sel.valid && !rd_is_x0;
            wb_addr_o <= sel.rd;
            // x0 stays zero on the write bus as well
            wb_data_o <= rd_is_x0 ? '0 : final_data;
        end
    end

endmodule

// File: logic/wb_sel_if.sv
`timescale 1ns/1ps

interface wb_sel_if;

    logic                      valid;
    wb_types_pkg::reg_addr_t   rd;
    wb_types_pkg::wr_sel_e     wr_sel;
    wb_types_pkg::load_e       load;
    wb_types_pkg::byte_off_t   byte_off;
    wb_map_pkg::region_e       region;
    wb_map_pkg::mmio_off_t     mmio_off;
    wb_types_pkg::word_t       alu_result;
    wb_types_pkg::word_t       pc_plus4;

    modport ctrl (
        output valid, rd, wr_sel, load, byte_off, region, mmio_off, alu_result, pc_plus4
    );

    // load extraction only needs the width and where the data sits
    modport align (
        input load, byte_off
    );

    modport mmio (
        input region, mmio_off
    );

    modport result (
        input valid, rd, wr_sel, alu_result, pc_plus4
    );

endinterface

// File: logic/wb_stage_top.sv
`timescale 1ns/1ps

module wb_stage_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // fields from the execute stage
    input  logic                     ex_valid_i,
    input  wb_types_pkg::reg_addr_t  ex_rd_i,
    input  wb_types_pkg::wr_sel_e    ex_wr_sel_i,
    input  wb_types_pkg::load_e      ex_load_i,
    input  wb_types_pkg::word_t      ex_alu_result_i,
    input  wb_types_pkg::word_t      ex_pc_plus4_i,

    // memory and register read data
    input  wb_types_pkg::word_t      dmem_rdata_i,
    input  wb_types_pkg::word_t      bios_rdata_i,
    input  logic [1:0]               uart_status_i,
    input  logic [7:0]               uart_rx_i,
    input  wb_types_pkg::word_t      conv_result_i,

    // register file write and hazard unit
    output logic                     wb_we_o,
    output wb_types_pkg::reg_addr_t  wb_addr_o,
    output wb_types_pkg::word_t      wb_data_o,
    output wb_types_pkg::word_t      wb_fwd_data_o,
    output logic                     wb_is_load_o
);

    wb_types_pkg::word_t dmem_load;
    wb_types_pkg::word_t bios_load;
    wb_types_pkg::word_t load_data;

    wb_sel_if sel_if ();

    // **********************************************************************
    // control
    // **********************************************************************

    wb_ctrl wb_ctrl_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ex_valid_i      (ex_valid_i),
        .ex_rd_i         (ex_rd_i),
        .ex_wr_sel_i     (ex_wr_sel_i),
        .ex_load_i       (ex_load_i),
        .ex_alu_result_i (ex_alu_result_i),
        .ex_pc_plus4_i   (ex_pc_plus4_i),
        .sel             (sel_if.ctrl)
    );

    // **********************************************************************
    // load path
    // **********************************************************************

    load_align dmem_align_inst (
        .sel     (sel_if.align),
        .rdata_i (dmem_rdata_i),
        .load_o  (dmem_load)
    );

    load_align bios_align_inst (
        .sel     (sel_if.align),
        .rdata_i (bios_rdata_i),
        .load_o  (bios_load)
    );

    mmio_read_mux mmio_read_mux_inst (
        .sel           (sel_if.mmio),
        .dmem_load_i   (dmem_load),
        .bios_load_i   (bios_load),
        .uart_status_i (uart_status_i),
        .uart_rx_i     (uart_rx_i),
        .conv_result_i (conv_result_i),
        .load_data_o   (load_data)
    );

    wb_result_mux wb_result_mux_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .sel           (sel_if.result),
        .load_data_i   (load_data),
        .wb_we_o       (wb_we_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .wb_fwd_data_o (wb_fwd_data_o),
        .wb_is_load_o  (wb_is_load_o)
    );

endmodule

// File: logic/wb_types_pkg.sv
package wb_types_pkg;

    // **********************************************************************
    // data word and register index
    // **********************************************************************

    localparam int unsigned XLEN   = 32;
    localparam int unsigned REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // position of a byte inside its 32-bit word
    typedef logic [1:0] byte_off_t;

    // **********************************************************************
    // writeback control encodings
    // **********************************************************************

    // loads are the only source that waits on memory read data
    typedef enum logic [1:0] {
        WR_ALU  = 2'b00,
        WR_PC4  = 2'b01,
        WR_LOAD = 2'b10
    } wr_sel_e;

    // same encoding as the funct3 field of the RV32I load instructions
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } load_e;

endpackage
